// File: design/mem_pkg.sv
package mem_pkg;

    // ======================================================================
    // data widths
    // ======================================================================

    typedef logic [63:0] dword_t;    // memory row, store data, load result
    typedef logic [63:0] addr_t;     // byte address
    typedef logic [31:0] inst_t;     // one instruction word

    typedef logic [7:0]  byte_mask_t;  // one bit per byte lane
    typedef logic [2:0]  byte_off_t;   // byte within a doubleword

    // ======================================================================
    // access width codes
    // ======================================================================

    typedef logic [1:0] width_t;

    localparam width_t WDT_8  = 2'd0;  // byte
    localparam width_t WDT_16 = 2'd1;  // halfword
    localparam width_t WDT_32 = 2'd2;  // word
    localparam width_t WDT_64 = 2'd3;  // doubleword

endpackage

// File: design/data_port_if.sv
interface data_port_if
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 8
) ();

    logic [DEPTH_LOG2-1:0] row;    // doubleword index
    logic                  ren;
    logic                  wen;
    byte_mask_t            wmask;
    dword_t                wdata;  // already placed in lanes
    dword_t                rdata;  // full row, registered in the memory

    modport requester (
        output row,
        output ren,
        output wen,
        output wmask,
        output wdata,
        input  rdata
    );

    modport memory (
        input  row,
        input  ren,
        input  wen,
        input  wmask,
        input  wdata,
        output rdata
    );

endinterface

// File: design/fetch_unit.sv
module fetch_unit
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 8
) (
    input  addr_t                 pc,
    input  dword_t                fetch_dword,
    output logic [DEPTH_LOG2-1:0] fetch_row,
    output inst_t                 inst,
    output logic                  inst_misaligned
);

    // doubleword index sits above the byte offset
    assign fetch_row = pc[DEPTH_LOG2+2:3];

    // pc[2] picks the half, low half first
    always_comb begin
        if (pc[2]) begin
            inst = fetch_dword[63:32];
        end else begin
            inst = fetch_dword[31:0];
        end
    end

    // no compressed support, just report it
    assign inst_misaligned = |pc[1:0];

endmodule

// File: design/data_unit.sv
module data_unit
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  addr_t                 mem_raddr,
    input  logic                  mem_ren,
    input  addr_t                 waddr,
    input  dword_t                mem_wdata,
    input  logic                  mem_wen,
    input  width_t                width,
    data_port_if.requester        dport,
    output dword_t                mem_rdata
);

    // round the offset down to the access size
    function automatic byte_off_t align_off(input byte_off_t off, input width_t w);
        byte_off_t keep;
        case (w)
            WDT_8:   keep = 3'b111;
            WDT_16:  keep = 3'b110;
            WDT_32:  keep = 3'b100;
            default: keep = 3'b000;
        endcase
        return off & keep;
    endfunction

    // ======================================================================
    // store side
    // ======================================================================

    byte_off_t  st_off;
    byte_mask_t st_base_mask;
    dword_t     st_lanes;

    assign st_off = align_off(waddr[2:0], width);

    always_comb begin
        case (width)
            WDT_8: begin
                st_base_mask = 8'h01;
                st_lanes     = {8{mem_wdata[7:0]}};
            end
            WDT_16: begin
                st_base_mask = 8'h03;
                st_lanes     = {4{mem_wdata[15:0]}};
            end
            WDT_32: begin
                st_base_mask = 8'h0f;
                st_lanes     = {2{mem_wdata[31:0]}};
            end
            default: begin
                st_base_mask = 8'hff;
                st_lanes     = mem_wdata;
            end
        endcase
    end

    assign dport.wen   = mem_wen;
    assign dport.wmask = st_base_mask << st_off;
    assign dport.wdata = st_lanes;  // every lane carries the data, mask picks

    // one row shared by both sides, load wins
    always_comb begin
        if (mem_ren) begin
            dport.row = mem_raddr[DEPTH_LOG2+2:3];
        end else begin
            dport.row = waddr[DEPTH_LOG2+2:3];
        end
    end

    // ======================================================================
    // load side
    // ======================================================================

    byte_off_t ld_off_q;
    width_t    ld_width_q;
    logic      ld_seen_q;   // set once the first load is issued
    dword_t    ld_shifted;
    dword_t    ld_field;

    assign dport.ren = mem_ren;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_off_q   <= '0;
            ld_width_q <= WDT_8;
            ld_seen_q  <= 1'b0;
        end else if (mem_ren) begin
            ld_off_q   <= align_off(mem_raddr[2:0], width);
            ld_width_q <= width;
            ld_seen_q  <= 1'b1;
        end
    end

    // bring the field down to bit 0
    assign ld_shifted = dport.rdata >> {ld_off_q, 3'b000};

    // zero extend, no signed loads here
    always_comb begin
        case (ld_width_q)
            WDT_8:   ld_field = {56'b0, ld_shifted[7:0]};
            WDT_16:  ld_field = {48'b0, ld_shifted[15:0]};
            WDT_32:  ld_field = {32'b0, ld_shifted[31:0]};
            default: ld_field = ld_shifted;
        endcase
    end

    // row data and capture both hold between loads
    assign mem_rdata = ld_seen_q ? ld_field : '0;

endmodule

// File: design/dword_memory.sv
module dword_memory
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic [DEPTH_LOG2-1:0] fetch_row,
    output dword_t                fetch_dword,
    data_port_if.memory           dport
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    // ======================================================================
    // storage
    // ======================================================================

    dword_t mem [0:DEPTH-1];
    dword_t rdata_q;

    // fetch port, same cycle
    assign fetch_dword = mem[fetch_row];

    // ======================================================================
    // data port
    // ======================================================================

    // read before write, the read samples the old row
    always_ff @(posedge clk) begin
        if (dport.ren) begin
            rdata_q <= mem[dport.row];
        end
    end

    always_ff @(posedge clk) begin
        if (dport.wen) begin
            for (int b = 0; b < 8; b++) begin
                if (dport.wmask[b]) begin
                    mem[dport.row][b*8 +: 8] <= dport.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign dport.rdata = rdata_q;  // held while ren is low

endmodule

// File: design/mem_stage.sv
module mem_stage
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic   clk,
    input  logic   reset,

    // fetch
    input  addr_t  pc,
    output inst_t  inst,
    output logic   inst_misaligned,

    // load
    input  addr_t  mem_raddr,
    input  logic   mem_ren,
    output dword_t mem_rdata,

    // store
    input  addr_t  waddr,
    input  dword_t mem_wdata,
    input  logic   mem_wen,
    input  width_t width
);

    logic [DEPTH_LOG2-1:0] fetch_row;
    dword_t                fetch_dword;

    data_port_if #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) dport ();

    // ======================================================================
    // blocks
    // ======================================================================

    fetch_unit #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) fetch_unit_i (
        .pc              (pc),
        .fetch_dword     (fetch_dword),
        .fetch_row       (fetch_row),
        .inst            (inst),
        .inst_misaligned (inst_misaligned)
    );

    data_unit #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) data_unit_i (
        .clk       (clk),
        .reset     (reset),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .waddr     (waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .width     (width),
        .dport     (dport.requester),
        .mem_rdata (mem_rdata)
    );

    dword_memory #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) dword_memory_i (
        .clk         (clk),
        .fetch_row   (fetch_row),
        .fetch_dword (fetch_dword),
        .dport       (dport.memory)
    );

endmodule

// File: dv/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ======================================================================
// shadow memory and random source
// ======================================================================

dword_t      shadow [0:DEPTH-1];
logic [31:0] lfsr_state = 32'hdb5f_b249;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit, newest bit ends up in bit 0
function automatic dword_t take_bits(input int n);
    dword_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[62:0], lfsr_state[0]};
    end
    return v;
endfunction

// ======================================================================
// reference rules
// ======================================================================

function automatic int access_bytes(input width_t w);
    return 1 << w;
endfunction

// low bits below the access size are dropped
function automatic int aligned_off(input addr_t a, input width_t w);
    int n;
    n = access_bytes(w);
    return (int'(a[2:0]) / n) * n;
endfunction

function automatic int row_of(input addr_t a);
    return int'(a[DEPTH_LOG2+2:3]);
endfunction

function automatic void shadow_store(input addr_t a, input dword_t d, input width_t w);
    int base;
    int n;
    int r;
    base = aligned_off(a, w);
    n    = access_bytes(w);
    r    = row_of(a);
    for (int i = 0; i < n; i++) begin
        shadow[r][(base + i) * 8 +: 8] = d[i * 8 +: 8];  // byte i of data to lane base+i
    end
endfunction

// zero extended field of the addressed row
function automatic dword_t ref_load(input addr_t a, input width_t w);
    dword_t v;
    int     base;
    int     n;
    int     r;
    v    = '0;
    base = aligned_off(a, w);
    n    = access_bytes(w);
    r    = row_of(a);
    for (int i = 0; i < n; i++) begin
        v[i * 8 +: 8] = shadow[r][(base + i) * 8 +: 8];
    end
    return v;
endfunction

function automatic inst_t ref_inst(input addr_t p);
    dword_t row_val;
    row_val = shadow[row_of(p)];
    if (p[2]) begin
        return row_val[63:32];
    end else begin
        return row_val[31:0];
    end
endfunction

function automatic logic ref_misaligned(input addr_t p);
    return p[1:0] != 2'b00;
endfunction

`endif

// File: dv/mem_stage_tb.sv
module mem_stage_tb
    import mem_pkg::*;
();

    localparam int DEPTH_LOG2 = 8;
    localparam int DEPTH      = 2 ** DEPTH_LOG2;

    // cycle budget per section
    localparam int RESET_CYCLES  = 3;
    localparam int ROUND_TRIP_N  = 64;
    localparam int PARTIAL_N     = 96;
    localparam int NARROW_ROWS   = 8;   // 14 loads per row
    localparam int RBW_ROWS      = 4;
    localparam int FETCH_ROWS    = 16;
    localparam int MISALIGN_ROWS = 4;
    localparam int PLAN_CYCLES   = RESET_CYCLES + 2 * ROUND_TRIP_N + 2 * PARTIAL_N
                                 + 14 * NARROW_ROWS + 2 * RBW_ROWS + 2 * FETCH_ROWS
                                 + 3 * MISALIGN_ROWS + 8;
    localparam int CYCLE_LIMIT   = 2 * PLAN_CYCLES + 100;

    logic   clk = 1'b0;
    logic   reset;
    addr_t  pc;
    inst_t  inst;
    logic   inst_misaligned;
    addr_t  mem_raddr;
    logic   mem_ren;
    dword_t mem_rdata;
    addr_t  waddr;
    dword_t mem_wdata;
    logic   mem_wen;
    width_t width;

    dword_t exp_rdata;
    dword_t held_rdata  = '0;  // last expected load result
    int     cycles      = 0;

    `include "tb_ref_model.svh"

    mem_stage #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) dut_i (
        .clk             (clk),
        .reset           (reset),
        .pc              (pc),
        .inst            (inst),
        .inst_misaligned (inst_misaligned),
        .mem_raddr       (mem_raddr),
        .mem_ren         (mem_ren),
        .mem_rdata       (mem_rdata),
        .waddr           (waddr),
        .mem_wdata       (mem_wdata),
        .mem_wen         (mem_wen),
        .width           (width)
    );

    always #4 clk = ~clk;

    // ======================================================================
    // checks
    // ======================================================================

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_dword(input dword_t got, input dword_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // mid high phase where rdata has settled and inputs are still stable
    always @(posedge clk) begin
        #2;
        if (!reset) begin
            if (mem_ren) begin
                held_rdata = exp_rdata;
            end
            check_dword(mem_rdata, held_rdata, "mem_rdata");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    function automatic addr_t row_addr(input int r, input int off);
        return addr_t'(r * 8 + off);
    endfunction

    task automatic drive_idle();
        @(negedge clk);
        mem_ren = 1'b0;
        mem_wen = 1'b0;
    endtask

    task automatic drive_store(input addr_t a, input dword_t d, input width_t w);
        @(negedge clk);
        waddr     = a;
        mem_wdata = d;
        width     = w;
        mem_wen   = 1'b1;
        mem_ren   = 1'b0;
        shadow_store(a, d, w);
    endtask

    task automatic drive_load(input addr_t a, input width_t w);
        @(negedge clk);
        mem_raddr = a;
        width     = w;
        mem_ren   = 1'b1;
        mem_wen   = 1'b0;
        exp_rdata = ref_load(a, w);
    endtask

    // same row on both sides and the load sees the old row
    task automatic drive_load_store(input addr_t a, input dword_t d);
        @(negedge clk);
        mem_raddr = a;
        waddr     = a;
        mem_wdata = d;
        width     = WDT_64;
        mem_ren   = 1'b1;
        mem_wen   = 1'b1;
        exp_rdata = ref_load(a, WDT_64);
        shadow_store(a, d, WDT_64);
    endtask

    task automatic check_fetch(input addr_t p);
        @(negedge clk);
        pc      = p;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        #2;
        check_inst(inst, ref_inst(p), $sformatf("inst at pc %h", p));
        check_flag(inst_misaligned, ref_misaligned(p), $sformatf("misaligned at pc %h", p));
    endtask

    initial begin
        int     r;
        int     off;
        width_t w;

        reset     = 1'b1;
        pc        = '0;
        mem_raddr = '0;
        mem_ren   = 1'b0;
        waddr     = '0;
        mem_wdata = '0;
        mem_wen   = 1'b0;
        width     = WDT_64;
        exp_rdata = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // rdata must read zero here
        drive_idle();
        drive_idle();

        for (r = 0; r < ROUND_TRIP_N; r++) begin
            drive_store(row_addr(r, 0), take_bits(64), WDT_64);
        end
        for (r = 0; r < ROUND_TRIP_N; r++) begin
            drive_load(row_addr(r, 0), WDT_64);
        end

        // partial stores with a full row read back
        for (int i = 0; i < PARTIAL_N; i++) begin
            r   = int'(take_bits(6));
            off = int'(take_bits(3));
            w   = width_t'(take_bits(8) % 3);
            drive_store(row_addr(r, off), take_bits(64), w);
            drive_load(row_addr(r, 0), WDT_64);
        end

        // narrow loads back to back
        for (r = 0; r < NARROW_ROWS; r++) begin
            for (int k = 0; k < 3; k++) begin
                w = width_t'(k);
                for (off = 0; off < 8; off += access_bytes(w)) begin
                    drive_load(row_addr(r, off), w);
                end
            end
        end

        for (r = 0; r < RBW_ROWS; r++) begin
            drive_load_store(row_addr(r, 0), take_bits(64));
            drive_load(row_addr(r, 0), WDT_64);
        end

        // ==================================================================
        // fetch
        // ==================================================================

        for (r = 0; r < FETCH_ROWS; r++) begin
            check_fetch(row_addr(r, 0));
            check_fetch(row_addr(r, 4));
        end
        for (r = 0; r < MISALIGN_ROWS; r++) begin
            check_fetch(row_addr(r, 1));
            check_fetch(row_addr(r, 2));
            check_fetch(row_addr(r, 6));
        end

        drive_idle();
        drive_idle();
        @(posedge clk);
        #4;
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+dv
design/mem_pkg.sv
design/data_port_if.sv
design/fetch_unit.sv
design/data_unit.sv
design/dword_memory.sv
design/mem_stage.sv
dv/mem_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the memory stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f all.f --top-module mem_stage_tb -o mem_stage_tb_sim; then
    echo "compile failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/mem_stage_tb_sim 2>&1); then
    echo "$sim_out"
    echo "simulation exited with an error status"
    exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
